// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gfx_main
RTL_TOP   ?= gfx_main
FILELIST  ?= gfx_main.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/1ps
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
PASS_MSG  ?= Test completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) common/gfx_defs.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== blitter/blit_ctrl.sv ====
`timescale 1ns/1ps

module blit_ctrl import gfx_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        start_i,            // one-cycle start from registers
    input  blit_cmd_t   cmd_i,              // length minus one and pattern
    input  addr_t       dst_i,              // first word to fill
    input  logic        vram_ack_i,
    output logic        vram_sel_o,
    output logic        vram_wr_o,
    output addr_t       vram_addr_o,
    output word_t       vram_data_o,
    output logic        busy_o,
    output logic        done_o              // pulse after last word written
);

localparam logic [1:0] ST_IDLE  = 2'd0;
localparam logic [1:0] ST_WRITE = 2'd1;
localparam logic [1:0] ST_DONE  = 2'd2;

logic [1:0] state;
logic [7:0] count;                          // words left minus one
reg_word_u  fill_q;                         // latched command

assign vram_sel_o  = (state == ST_WRITE);
assign vram_wr_o   = vram_sel_o;            // fill only ever writes
assign vram_data_o = {fill_q.cmd.pattern, fill_q.cmd.pattern};
assign busy_o      = (state != ST_IDLE);
assign done_o      = (state == ST_DONE);

always_ff @(posedge clk) begin
    if (reset_i) begin
        state <= ST_IDLE;
    end else begin
        case (state)
            ST_IDLE: begin
                if (start_i) begin
                    state <= ST_WRITE;
                end
            end
            ST_WRITE: begin
                if (vram_ack_i && count == 8'd0) begin
                    state <= ST_DONE;       // last word acked
                end
            end
            ST_DONE:  state <= ST_IDLE;
            default:  state <= ST_IDLE;
        endcase
    end
end

// address and count only mean something in ST_WRITE
always_ff @(posedge clk) begin
    if (state == ST_IDLE && start_i) begin
        fill_q.cmd  <= cmd_i;
        count       <= cmd_i.len;
        vram_addr_o <= dst_i;
    end else if (state == ST_WRITE && vram_ack_i) begin
        count       <= count - 8'd1;
        vram_addr_o <= vram_addr_o + 1'b1;  // next word, one per ack
    end
end

endmodule

// ==== common/gfx_defs.svh ====
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// vram address width in words
`define VRAM_ADDR_W     10

// horizontal timing in pixels, tiny frame for simulation
`define H_TOTAL         24
`define H_VISIBLE       16
`define H_SYNC_START    18
`define H_SYNC_END      20

// vertical timing in lines, vsync is a single line
`define V_TOTAL         10
`define V_VISIBLE       8
`define V_SYNC_START    8

// register numbers on the 3-bit bus_reg_i
`define REG_WR_ADDR     3'd0
`define REG_DATA        3'd1
`define REG_RD_ADDR     3'd2
`define REG_DATA_RD     3'd3
`define REG_BLIT_DST    3'd4
`define REG_BLIT_CMD    3'd5
`define REG_INT_CTRL    3'd6
`define REG_STATUS      3'd7

`endif

// ==== common/gfx_pkg.sv ====
`include "gfx_defs.svh"

package gfx_pkg;

    typedef logic [15:0] word_t;                    // vram / register data word
    typedef logic [`VRAM_ADDR_W-1:0] addr_t;        // vram word address

    // bit 0 blit done, bit 1 vertical blank
    typedef logic [1:0] intr_t;

    // fill command as written to BLIT_CMD
    typedef struct packed {
        logic [7:0] len;                            // word count minus one
        logic [7:0] pattern;                        // fill byte, replicated into both halves
    } blit_cmd_t;

    // a register write word, seen raw or as a blit command
    typedef union packed {
        word_t     word;
        blit_cmd_t cmd;
    } reg_word_u;

endpackage

// ==== gfx_main.f ====
+incdir+common
common/gfx_pkg.sv
logic/reg_interface.sv
logic/vram_arb.sv
blitter/blit_ctrl.sv
logic/video_timing.sv
logic/gfx_main.sv
tests/tb_gfx_main.sv

// ==== logic/gfx_main.sv ====
`timescale 1ns/1ps

module gfx_main import gfx_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_valid_i,        // register port request
    input  logic        bus_wr_i,
    input  logic [2:0]  bus_reg_i,
    input  word_t       bus_data_i,
    output logic        bus_ready_o,
    output logic        rd_valid_o,         // read data return
    output word_t       rd_data_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        dv_de_o,
    output logic        bus_intr_o          // cpu interrupt
);

// register client vram port
logic       regs_sel;
logic       regs_wr;
logic       regs_ack;
addr_t      regs_addr;
word_t      regs_data;

// blitter vram port
logic       blit_sel;
logic       blit_wr;
logic       blit_ack;
addr_t      blit_addr;
word_t      blit_data;

word_t      vram_data;                      // shared read data
logic       blit_start;
blit_cmd_t  blit_cmd;
addr_t      blit_dst;
logic       blit_busy;
logic       blit_done;
logic       v_blank;
logic       vblank_strobe;

reg_interface i_reg_interface (
    .clk(clk),                  .reset_i(reset_i),
    .bus_valid_i(bus_valid_i),  .bus_wr_i(bus_wr_i),
    .bus_reg_i(bus_reg_i),      .bus_data_i(bus_data_i),
    .bus_ready_o(bus_ready_o),  .rd_valid_o(rd_valid_o),
    .rd_data_o(rd_data_o),
    .vram_sel_o(regs_sel),      .vram_wr_o(regs_wr),
    .vram_addr_o(regs_addr),    .vram_data_o(regs_data),
    .vram_ack_i(regs_ack),      .vram_data_i(vram_data),
    .blit_start_o(blit_start),  .blit_cmd_o(blit_cmd),
    .blit_dst_o(blit_dst),
    .blit_busy_i(blit_busy),    .blit_done_i(blit_done),
    .v_blank_i(v_blank),        .vblank_strobe_i(vblank_strobe),
    .bus_intr_o(bus_intr_o)
);

vram_arb i_vram_arb (
    .clk(clk),
    .regs_sel_i(regs_sel),      .regs_wr_i(regs_wr),
    .regs_addr_i(regs_addr),    .regs_data_i(regs_data),
    .regs_ack_o(regs_ack),
    .blit_sel_i(blit_sel),      .blit_wr_i(blit_wr),
    .blit_addr_i(blit_addr),    .blit_data_i(blit_data),
    .blit_ack_o(blit_ack),
    .vram_data_o(vram_data)
);

blit_ctrl i_blit_ctrl (
    .clk(clk),                  .reset_i(reset_i),
    .start_i(blit_start),       .cmd_i(blit_cmd),
    .dst_i(blit_dst),           .vram_ack_i(blit_ack),
    .vram_sel_o(blit_sel),      .vram_wr_o(blit_wr),
    .vram_addr_o(blit_addr),    .vram_data_o(blit_data),
    .busy_o(blit_busy),         .done_o(blit_done)
);

video_timing i_video_timing (
    .clk(clk),                  .reset_i(reset_i),
    .hsync_o(hsync_o),          .vsync_o(vsync_o),
    .dv_de_o(dv_de_o),          .v_blank_o(v_blank),
    .vblank_strobe_o(vblank_strobe)
);

endmodule

// ==== logic/reg_interface.sv ====
`timescale 1ns/1ps

`include "gfx_defs.svh"

module reg_interface import gfx_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        bus_valid_i,        // cpu request
    input  logic        bus_wr_i,           // 1 = write, 0 = read
    input  logic [2:0]  bus_reg_i,          // register number
    input  word_t       bus_data_i,         // write data
    output logic        bus_ready_o,        // transfer accepted when valid & ready
    output logic        rd_valid_o,         // one pulse per accepted read
    output word_t       rd_data_o,
    output logic        vram_sel_o,         // held until vram_ack_i
    output logic        vram_wr_o,
    output addr_t       vram_addr_o,
    output word_t       vram_data_o,
    input  logic        vram_ack_i,
    input  word_t       vram_data_i,        // valid with ack
    output logic        blit_start_o,       // one-cycle start strobe
    output blit_cmd_t   blit_cmd_o,
    output addr_t       blit_dst_o,
    input  logic        blit_busy_i,
    input  logic        blit_done_i,
    input  logic        v_blank_i,
    input  logic        vblank_strobe_i,
    output logic        bus_intr_o          // cpu interrupt strobe
);

logic       accept;                         // transfer this cycle
logic       blit_stall;                     // blitter busy or about to be
reg_word_u  wr_word;                        // decoded view of bus_data_i
intr_t      intr_mask;
intr_t      intr_status;                    // latched pending interrupts
intr_t      intr_signal;                    // new interrupt events this cycle
intr_t      intr_clear;                     // bits cleared by INT_CTRL write
addr_t      wr_ptr;
addr_t      rd_ptr;
word_t      rd_word;                        // read mux for non-vram registers

assign wr_word     = bus_data_i;
assign blit_stall  = blit_busy_i | blit_start_o;    // start is in flight one cycle before busy

// stall behind our own vram access, or a second fill while one runs
assign bus_ready_o = ~vram_sel_o &
                     ~(bus_wr_i && bus_reg_i == `REG_BLIT_CMD && blit_stall);
assign accept      = bus_valid_i & bus_ready_o;

assign intr_signal = {vblank_strobe_i, blit_done_i};
assign intr_clear  = (accept && bus_wr_i && bus_reg_i == `REG_INT_CTRL) ?
                     wr_word.word[1:0] : 2'b00;

always_comb begin
    case (bus_reg_i)
        `REG_WR_ADDR:  rd_word = word_t'(wr_ptr);
        `REG_RD_ADDR:  rd_word = word_t'(rd_ptr);
        `REG_BLIT_DST: rd_word = word_t'(blit_dst_o);
        `REG_INT_CTRL: rd_word = {6'b0, intr_mask, 6'b0, intr_status};   // mask hi, status lo
        `REG_STATUS:   rd_word = {14'b0, v_blank_i, blit_stall};
        default:       rd_word = '0;                                      // DATA, BLIT_CMD
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_sel_o   <= 1'b0;
        rd_valid_o   <= 1'b0;
        blit_start_o <= 1'b0;
        intr_mask    <= '0;
        intr_status  <= '0;
        bus_intr_o   <= 1'b0;
        wr_ptr       <= '0;
        rd_ptr       <= '0;
    end else begin
        rd_valid_o   <= 1'b0;               // strobes
        blit_start_o <= 1'b0;
        if (vram_ack_i) begin
            vram_sel_o <= 1'b0;
            rd_valid_o <= ~vram_wr_o;       // only DATA_RD returns data
        end
        if (accept) begin
            if (bus_wr_i) begin
                case (bus_reg_i)
                    `REG_WR_ADDR:  wr_ptr <= bus_data_i[`VRAM_ADDR_W-1:0];
                    `REG_RD_ADDR:  rd_ptr <= bus_data_i[`VRAM_ADDR_W-1:0];
                    `REG_DATA: begin
                        vram_sel_o <= 1'b1;
                        wr_ptr     <= wr_ptr + 1'b1;    // address already latched below
                    end
                    `REG_BLIT_CMD: blit_start_o <= 1'b1;
                    `REG_INT_CTRL: intr_mask <= wr_word.word[9:8];
                    default: ;
                endcase
            end else if (bus_reg_i == `REG_DATA_RD) begin
                vram_sel_o <= 1'b1;
                rd_ptr     <= rd_ptr + 1'b1;
            end else begin
                rd_valid_o <= 1'b1;         // register read, data next cycle
            end
        end
        // interrupt only for a new, enabled, not already pending bit
        bus_intr_o  <= |(intr_signal & intr_mask & ~intr_status);
        intr_status <= (intr_status | intr_signal) & ~intr_clear;
    end
end

// payload, qualified by the control state above
always_ff @(posedge clk) begin
    if (vram_ack_i && !vram_wr_o) begin
        rd_data_o <= vram_data_i;
    end else if (accept && !bus_wr_i) begin
        rd_data_o <= rd_word;
    end
    if (accept) begin
        vram_wr_o   <= bus_wr_i;
        vram_addr_o <= bus_wr_i ? wr_ptr : rd_ptr;
        vram_data_o <= bus_data_i;
        if (bus_wr_i && bus_reg_i == `REG_BLIT_DST) begin
            blit_dst_o <= bus_data_i[`VRAM_ADDR_W-1:0];
        end
        if (bus_wr_i && bus_reg_i == `REG_BLIT_CMD) begin
            blit_cmd_o <= wr_word.cmd;
        end
    end
end

endmodule

// ==== logic/video_timing.sv ====
`timescale 1ns/1ps

`include "gfx_defs.svh"

module video_timing (
    input  logic    clk,
    input  logic    reset_i,
    output logic    hsync_o,                // active high
    output logic    vsync_o,                // active high, one line
    output logic    dv_de_o,                // visible pixel
    output logic    v_blank_o,              // below visible lines
    output logic    vblank_strobe_o         // first pixel of first blank line
);

localparam int H_W = $clog2(`H_TOTAL);
localparam int V_W = $clog2(`V_TOTAL);

logic [H_W-1:0] h_count;                    // pixel in line
logic [V_W-1:0] v_count;                    // line in frame
logic           h_last;

assign h_last = (h_count == H_W'(`H_TOTAL - 1));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else if (h_last) begin
        h_count <= '0;
        if (v_count == V_W'(`V_TOTAL - 1)) begin
            v_count <= '0;                  // wrap frame
        end else begin
            v_count <= v_count + 1'b1;
        end
    end else begin
        h_count <= h_count + 1'b1;
    end
end

assign hsync_o   = (h_count >= H_W'(`H_SYNC_START)) && (h_count < H_W'(`H_SYNC_END));
assign vsync_o   = (v_count == V_W'(`V_SYNC_START));
assign v_blank_o = (v_count >= V_W'(`V_VISIBLE));
assign dv_de_o   = (h_count < H_W'(`H_VISIBLE)) && !v_blank_o;

// once per frame
assign vblank_strobe_o = (h_count == '0) && (v_count == V_W'(`V_VISIBLE));

endmodule

// ==== logic/vram_arb.sv ====
`timescale 1ns/1ps

`include "gfx_defs.svh"

module vram_arb import gfx_pkg::*; (
    input  logic    clk,
    // register interface client, highest priority
    input  logic    regs_sel_i,
    input  logic    regs_wr_i,
    input  addr_t   regs_addr_i,
    input  word_t   regs_data_i,
    output logic    regs_ack_o,
    // blitter client
    input  logic    blit_sel_i,
    input  logic    blit_wr_i,
    input  addr_t   blit_addr_i,
    input  word_t   blit_data_i,
    output logic    blit_ack_o,
    // shared read data, valid with either ack
    output word_t   vram_data_o
);

localparam int DEPTH = 1 << `VRAM_ADDR_W;

word_t  mem [DEPTH];                        // vram array
logic   regs_go;                            // grant register client this cycle
logic   blit_go;                            // grant blitter this cycle

// sel is still high in the ack cycle, so no grant while acking
assign regs_go = regs_sel_i & ~regs_ack_o;
assign blit_go = blit_sel_i & ~blit_ack_o & ~regs_go;  // blitter waits behind regs

always_ff @(posedge clk) begin
    regs_ack_o <= regs_go;
    blit_ack_o <= blit_go;
    if (regs_go) begin
        if (regs_wr_i) begin
            mem[regs_addr_i] <= regs_data_i;
        end
        vram_data_o <= mem[regs_addr_i];    // old data on write, not used
    end else if (blit_go) begin
        if (blit_wr_i) begin
            mem[blit_addr_i] <= blit_data_i;
        end
        vram_data_o <= mem[blit_addr_i];
    end
end

endmodule

// ==== tests/gfx_stim.txt ====
# test op reg data mask, reg in decimal, data and mask in hex
# W writes data, R compares the read under mask, P re-reads until it matches under mask
1 W 0 0010 0000
1 W 1 1111 0000
1 W 1 2222 0000
1 W 1 3333 0000
1 W 2 0010 0000
1 R 3 1111 ffff
1 R 3 2222 ffff
1 R 3 3333 ffff
2 W 0 003f 0000
2 W 1 dead 0000
2 W 0 0044 0000
2 W 1 beef 0000
2 W 4 0040 0000
2 W 5 035a 0000
2 P 7 0000 0001
2 W 2 003f 0000
2 R 3 dead ffff
2 R 3 5a5a ffff
2 R 3 5a5a ffff
2 R 3 5a5a ffff
2 R 3 5a5a ffff
2 R 3 beef ffff
2 R 6 0001 0301
5 W 4 0100 0000
5 W 5 3fa5 0000
5 W 0 0200 0000
5 W 1 0a0a 0000
5 W 1 0b0b 0000
5 W 1 0c0c 0000
5 R 7 0001 0001
5 P 7 0000 0001
5 W 2 0200 0000
5 R 3 0a0a ffff
5 R 3 0b0b ffff
5 R 3 0c0c ffff
5 W 2 0100 0000
5 R 3 a5a5 ffff
5 R 3 a5a5 ffff
5 W 2 013f 0000
5 R 3 a5a5 ffff

// ==== tests/tb_gfx_main.sv ====
`timescale 1ns/1ps

`include "gfx_defs.svh"

module tb_gfx_main;

localparam int FRAME = `H_TOTAL * `V_TOTAL;     // clocks per frame

logic        clk;
logic        reset_i;
logic        bus_valid_i;
logic        bus_wr_i;
logic [2:0]  bus_reg_i;
logic [15:0] bus_data_i;
logic        bus_ready_o;
logic        rd_valid_o;
logic [15:0] rd_data_o;
logic        hsync_o;
logic        vsync_o;
logic        dv_de_o;
logic        bus_intr_o;

int          test_errs;                         // errors in the running test
int          pass_count;
int          fail_count;
int          intr_count;                        // bus_intr_o pulses seen
int          limit_cycles;                      // watchdog budget, 0 until known
logic [15:0] lfsr;
int          s_num[$];                          // stimulus columns
logic [7:0]  s_op[$];
int          s_reg[$];
logic [15:0] s_data[$];
logic [15:0] s_mask[$];

gfx_main i_dut (
    .clk(clk),                  .reset_i(reset_i),
    .bus_valid_i(bus_valid_i),  .bus_wr_i(bus_wr_i),
    .bus_reg_i(bus_reg_i),      .bus_data_i(bus_data_i),
    .bus_ready_o(bus_ready_o),  .rd_valid_o(rd_valid_o),
    .rd_data_o(rd_data_o),
    .hsync_o(hsync_o),          .vsync_o(vsync_o),
    .dv_de_o(dv_de_o),          .bus_intr_o(bus_intr_o)
);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                     // 20 ns
end

always @(negedge clk) begin
    if (bus_intr_o === 1'b1) intr_count = intr_count + 1;   // one per pulse
end

initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles", limit_cycles);
    $display("Test failed");
    $finish;
end

// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr_next(lfsr);                 // one step per bit
        v    = {v[14:0], lfsr[0]};
    end
    return v;
endfunction

// one transfer, inputs held until valid & ready
task automatic bus_xfer(input logic wr, input logic [2:0] rg, input logic [15:0] data);
    @(posedge clk);
    #1;
    bus_valid_i = 1'b1;
    bus_wr_i    = wr;
    bus_reg_i   = rg;
    bus_data_i  = data;
    @(negedge clk);
    while (!bus_ready_o) @(negedge clk);        // ready settled mid cycle
    @(posedge clk);                             // transfer edge
    #1;
    bus_valid_i = 1'b0;
endtask

task automatic read_reg(input logic [2:0] rg, output logic [15:0] got, output logic ok);
    int n;
    n = 0;
    bus_xfer(1'b0, rg, 16'h0000);
    @(negedge clk);
    while (!rd_valid_o && n < 100) begin
        @(negedge clk);
        n++;
    end
    ok  = rd_valid_o;
    got = rd_data_o;
    if (!ok) begin
        $display("no read data returned for register %0d", rg);
        test_errs++;
    end
endtask

task automatic check_reg(input logic [2:0] rg, input logic [15:0] exp, input logic [15:0] mask);
    logic [15:0] got;
    logic        ok;
    read_reg(rg, got, ok);
    if (ok && ((got & mask) != (exp & mask))) begin
        $display("ERR rd_data_o reg %0d expected %h got %h mask %h", rg, exp, got, mask);
        test_errs++;
    end
endtask

// repeat a read until the masked value shows up
task automatic poll_reg(input logic [2:0] rg, input logic [15:0] exp, input logic [15:0] mask);
    logic [15:0] got;
    logic        ok;
    int          tries;
    tries = 0;
    do begin
        read_reg(rg, got, ok);
        tries++;
    end while (ok && ((got & mask) != (exp & mask)) && tries < 500);
    if (ok && ((got & mask) != (exp & mask))) begin
        $display("register %0d never reached %h after %0d reads", rg, exp, tries);
        test_errs++;
    end
endtask

// vsync width, then one visible line from its first pixel
task automatic check_sync_timing();
    int vs_cnt;
    int hs_cnt;
    int hs_at;
    int de_cnt;
    vs_cnt = 0;
    hs_cnt = 0;
    hs_at  = -1;
    de_cnt = 0;
    @(negedge clk);
    while (vsync_o) @(negedge clk);
    while (!vsync_o) @(negedge clk);            // first clock of the vsync line
    while (vsync_o) begin
        vs_cnt++;
        @(negedge clk);
    end
    if (vs_cnt != `H_TOTAL) begin
        $display("ERR vsync_o cycles expected %h got %h", `H_TOTAL, vs_cnt);
        test_errs++;
    end
    while (!dv_de_o) @(negedge clk);            // pixel 0 of line 0
    for (int i = 0; i < `H_TOTAL; i++) begin
        if (dv_de_o) begin
            de_cnt++;
        end
        if (hsync_o) begin
            hs_cnt++;
            if (hs_at < 0) begin
                hs_at = i;
            end
        end
        @(negedge clk);
    end
    if (de_cnt != `H_VISIBLE) begin
        $display("ERR dv_de_o cycles expected %h got %h", `H_VISIBLE, de_cnt);
        test_errs++;
    end
    if (hs_at != `H_SYNC_START) begin
        $display("ERR hsync_o start expected %h got %h", `H_SYNC_START, hs_at);
        test_errs++;
    end
    if (hs_cnt != `H_SYNC_END - `H_SYNC_START) begin
        $display("ERR hsync_o cycles expected %h got %h",
                 `H_SYNC_END - `H_SYNC_START, hs_cnt);
        test_errs++;
    end
endtask

task automatic end_test(input int num, input string name);
    if (test_errs == 0) begin
        pass_count++;
        $display("test %0d (%s) ok", num, name);
    end else begin
        fail_count++;
        $display("test %0d (%s) FAIL with %0d errors", num, name, test_errs);
    end
    test_errs = 0;
endtask

initial begin
    int          fd;
    int          n;
    int          num;
    int          rg;
    int          cur;
    string       line;
    logic [7:0]  op;
    logic [15:0] data;
    logic [15:0] mask;
    logic [15:0] base;
    logic [15:0] words [32];

    bus_valid_i = 1'b0;
    bus_wr_i    = 1'b0;
    bus_reg_i   = 3'd0;
    bus_data_i  = 16'h0000;
    reset_i     = 1'b1;
    test_errs   = 0;
    pass_count  = 0;
    fail_count  = 0;
    intr_count  = 0;
    lfsr        = 16'd79;

    fd = $fopen("tests/gfx_stim.txt", "r");
    if (fd == 0) begin
        $display("cannot open tests/gfx_stim.txt");
        fail_count++;
    end else begin
        while (!$feof(fd)) begin
            n = $fgets(line, fd);               // comment lines fail the scan
            if (n > 0 && $sscanf(line, "%d %s %d %h %h", num, op, rg, data, mask) == 5) begin
                s_num.push_back(num);
                s_op.push_back(op);
                s_reg.push_back(rg);
                s_data.push_back(data);
                s_mask.push_back(mask);
            end
        end
        $fclose(fd);
    end
    limit_cycles = (s_num.size() + 100) * 200 + 4 * FRAME;  // extra ops for coded tests

    repeat (4) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // file driven tests 1, 2 and 5
    cur = (s_num.size() > 0) ? s_num[0] : 0;
    for (int i = 0; i < s_num.size(); i++) begin
        if (s_num[i] != cur) begin
            end_test(cur, "stimulus file");
            cur = s_num[i];
        end
        case (s_op[i])
            "W":     bus_xfer(1'b1, 3'(s_reg[i]), s_data[i]);
            "R":     check_reg(3'(s_reg[i]), s_data[i], s_mask[i]);
            "P":     poll_reg(3'(s_reg[i]), s_data[i], s_mask[i]);
            default: begin
                $display("unknown op on stimulus entry %0d", i + 1);
                test_errs++;
            end
        endcase
    end
    if (s_num.size() > 0) end_test(cur, "stimulus file");

    // blit done interrupt, masked in then masked out
    bus_xfer(1'b1, `REG_INT_CTRL, 16'h0103);    // mask bit 0, clear both
    intr_count = 0;
    bus_xfer(1'b1, `REG_BLIT_DST, 16'h0300);
    bus_xfer(1'b1, `REG_BLIT_CMD, 16'h0111);    // two words of 1111
    poll_reg(`REG_STATUS, 16'h0000, 16'h0001);
    check_reg(`REG_INT_CTRL, 16'h0101, 16'h0301);
    if (intr_count != 1) begin
        $display("ERR bus_intr_o pulses expected %h got %h", 1, intr_count);
        test_errs++;
    end
    bus_xfer(1'b1, `REG_INT_CTRL, 16'h0101);    // clear bit 0, mask kept
    check_reg(`REG_INT_CTRL, 16'h0100, 16'h0301);
    bus_xfer(1'b1, `REG_INT_CTRL, 16'h0000);
    intr_count = 0;
    bus_xfer(1'b1, `REG_BLIT_CMD, 16'h0022);
    poll_reg(`REG_STATUS, 16'h0000, 16'h0001);
    check_reg(`REG_INT_CTRL, 16'h0001, 16'h0301);   // latched without a pulse
    if (intr_count != 0) begin
        $display("ERR bus_intr_o pulses expected %h got %h", 0, intr_count);
        test_errs++;
    end
    end_test(3, "blit done interrupt");

    // vblank interrupt and status
    bus_xfer(1'b1, `REG_INT_CTRL, 16'h0203);
    intr_count = 0;
    n = 0;
    while (intr_count == 0 && n < 2 * FRAME) begin
        @(negedge clk);
        n++;
    end
    if (intr_count == 0) begin
        $display("no vblank interrupt within two frames");
        test_errs++;
    end
    @(negedge clk);
    while (!vsync_o) @(negedge clk);
    check_reg(`REG_STATUS, 16'h0002, 16'h0002); // still in the vsync line
    @(negedge clk);
    while (!dv_de_o) @(negedge clk);
    check_reg(`REG_STATUS, 16'h0000, 16'h0002);
    check_sync_timing();
    end_test(4, "vblank interrupt");

    // random words at a random base
    base = rand_bits(10);
    bus_xfer(1'b1, `REG_WR_ADDR, base);
    for (int i = 0; i < 32; i++) begin
        words[i] = rand_bits(16);
        bus_xfer(1'b1, `REG_DATA, words[i]);
    end
    bus_xfer(1'b1, `REG_RD_ADDR, base);
    for (int i = 0; i < 32; i++) begin
        check_reg(`REG_DATA_RD, words[i], 16'hffff);
    end
    end_test(6, "random data");

    $display("passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule
